// ==== Bender.yml ====
package:
  name: dcore

sources:
  - design/dcore_pkg.sv
  - design/adc_unfold.sv
  - design/prbs_gen.sv
  - design/prbs_checker.sv
  - design/cdr_pi_ctl.sv
  - design/dcore_top.sv
  - target: simulation
    files:
      - sim/tb_dcore.sv

// ==== design/adc_unfold.sv ====
module adc_unfold (
    input  wire logic                               clk_adc,
    input  wire logic                               cdr_rstb,
    input  wire logic [dcore_pkg::n_adc-1:0]        adc_mag_i [dcore_pkg::n_ti],
    input  wire logic [dcore_pkg::n_ti-1:0]         adc_sign_i,
    input  wire logic signed [dcore_pkg::n_adc-1:0] bit_level_i,
    output logic signed [dcore_pkg::n_adc-1:0]      adc_code_o [dcore_pkg::n_ti],
    output logic [dcore_pkg::n_ti-1:0]              rx_bits_o
);

    logic signed [dcore_pkg::n_adc-1:0] code_d [dcore_pkg::n_ti];
    logic [dcore_pkg::n_ti-1:0]         bit_d;

    // sign set means positive magnitude
    always_comb begin
        for (int k = 0; k < dcore_pkg::n_ti; k++) begin
            code_d[k] = adc_sign_i[k] ? adc_mag_i[k] : -adc_mag_i[k];
            // slicer, strictly above the level gives a one
            bit_d[k] = (code_d[k] > bit_level_i);
        end
    end

    // codes and sliced bits leave together, one cycle later
    always_ff @(posedge clk_adc or negedge cdr_rstb) begin
        if (!cdr_rstb) begin
            for (int k = 0; k < dcore_pkg::n_ti; k++) begin
                adc_code_o[k] <= '0;
            end
            rx_bits_o <= '0;
        end else begin
            for (int k = 0; k < dcore_pkg::n_ti; k++) begin
                adc_code_o[k] <= code_d[k];
            end
            rx_bits_o <= bit_d;
        end
    end

endmodule

// ==== design/cdr_pi_ctl.sv ====
module cdr_pi_ctl (
    input  wire logic                            clk_adc,
    input  wire logic                            cdr_rstb,
    input  wire logic [dcore_pkg::n_pi-1:0]      pi_code_i [dcore_pkg::n_out],
    input  wire logic [dcore_pkg::n_max_sel-1:0] max_sel_i [dcore_pkg::n_out],
    input  wire logic                            ext_scale_en_i,
    input  wire logic [dcore_pkg::n_pi-1:0]      ext_scale_i [dcore_pkg::n_out],
    input  wire logic [dcore_pkg::n_pi-1:0]      pi_offset_i [dcore_pkg::n_out],
    output logic [dcore_pkg::n_pi-1:0]           int_pi_ctl_o [dcore_pkg::n_out],
    output logic                                 ctl_valid_o
);

    logic [dcore_pkg::n_valid_wait-1:0] wait_q;
    logic                               wait_done;
    logic [dcore_pkg::n_pi-1:0]         sel_ext [dcore_pkg::n_out];
    logic [dcore_pkg::n_pi-1:0]         scale [dcore_pkg::n_out];

    //////////////////////////////////////////////////////////////////////
    // post-reset wait
    //////////////////////////////////////////////////////////////////////

    assign wait_done = &wait_q;

    // saturates at 31, valid follows one edge after
    always_ff @(posedge clk_adc or negedge cdr_rstb) begin
        if (!cdr_rstb) begin
            wait_q      <= '0;
            ctl_valid_o <= 1'b0;
        end else begin
            if (!wait_done) begin
                wait_q <= wait_q + 1'b1;
            end
            ctl_valid_o <= wait_done;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // pi control words
    //////////////////////////////////////////////////////////////////////

    // max_sel of 31 wraps to 0 before the minus one, giving 511
    always_comb begin
        for (int j = 0; j < dcore_pkg::n_out; j++) begin
            sel_ext[j] = dcore_pkg::n_pi'(max_sel_i[j]);
            if (ext_scale_en_i) begin
                scale[j] = ext_scale_i[j];
            end else begin
                scale[j] = ((sel_ext[j] + 1'b1) << dcore_pkg::n_scale_shift) - 1'b1;
            end
            int_pi_ctl_o[j] = (pi_code_i[j] % scale[j]) + pi_offset_i[j];
        end
    end

endmodule

// ==== design/dcore_pkg.sv ====
package dcore_pkg;

    //////////////////////////////////////////////////////////////////////
    // datapath sizes
    //////////////////////////////////////////////////////////////////////

    // interleaved lanes, adc magnitude and signed code width
    localparam int n_ti = 4;
    localparam int n_adc = 8;

    // phase interpolator outputs and control word width
    localparam int n_out = 4;
    localparam int n_pi = 9;

    // analog max-select field
    localparam int n_max_sel = 5;

    // post-reset wait, flag rises once the counter sits at all ones
    localparam int n_valid_wait = 5;

    // internal scale is ((max_sel + 1) << n_scale_shift) - 1
    localparam int n_scale_shift = 4;

    //////////////////////////////////////////////////////////////////////
    // prbs
    //////////////////////////////////////////////////////////////////////

    // prbs7, x^7 + x^6 + 1
    localparam int prbs_len = 7;
    localparam int prbs_tap_a = 7;
    localparam int prbs_tap_b = 6;
    localparam logic [prbs_len-1:0] prbs_seed = '1;

    //////////////////////////////////////////////////////////////////////
    // error and total counters
    //////////////////////////////////////////////////////////////////////

    localparam int n_count = 64;
    localparam int n_half = n_count / 2;

    // wide enough to hold a count of 0..n_ti lanes
    localparam int n_lane_cnt = $clog2(n_ti + 1);

    typedef struct packed {
        logic [n_half-1:0] upper;
        logic [n_half-1:0] lower;
    } count_halves_t;

    // one count word, read whole or as two 32-bit halves
    typedef union packed {
        logic [n_count-1:0] full;
        count_halves_t      half;
    } count_word_u;

endpackage

// ==== design/dcore_top.sv ====
module dcore_top (
    input  wire logic                               clk_adc,
    input  wire logic                               cdr_rstb,
    // adc front end
    input  wire logic [dcore_pkg::n_adc-1:0]        adc_mag_i [dcore_pkg::n_ti],
    input  wire logic [dcore_pkg::n_ti-1:0]         adc_sign_i,
    input  wire logic signed [dcore_pkg::n_adc-1:0] bit_level_i,
    output logic signed [dcore_pkg::n_adc-1:0]      adc_code_o [dcore_pkg::n_ti],
    // bist generator
    input  wire logic                               gen_cke_i,
    input  wire logic                               inj_err_i,
    // prbs checker
    input  wire logic                               chk_cke_i,
    input  wire logic                               sel_bist_i,
    input  wire logic [dcore_pkg::n_ti-1:0]         chan_sel_i,
    input  wire logic [1:0]                         count_sel_i,
    output logic [dcore_pkg::n_half-1:0]            count_o,
    // phase interpolator control
    input  wire logic [dcore_pkg::n_pi-1:0]         pi_code_i [dcore_pkg::n_out],
    input  wire logic [dcore_pkg::n_max_sel-1:0]    max_sel_i [dcore_pkg::n_out],
    input  wire logic                               ext_scale_en_i,
    input  wire logic [dcore_pkg::n_pi-1:0]         ext_scale_i [dcore_pkg::n_out],
    input  wire logic [dcore_pkg::n_pi-1:0]         pi_offset_i [dcore_pkg::n_out],
    output logic [dcore_pkg::n_pi-1:0]              int_pi_ctl_o [dcore_pkg::n_out],
    output logic                                    ctl_valid_o
);

    // sliced adc bits and bist bits into the checker
    logic [dcore_pkg::n_ti-1:0] rx_bits;
    logic [dcore_pkg::n_ti-1:0] bist_bits;

    adc_unfold i_adc_unfold (
        .clk_adc     (clk_adc),
        .cdr_rstb    (cdr_rstb),
        .adc_mag_i   (adc_mag_i),
        .adc_sign_i  (adc_sign_i),
        .bit_level_i (bit_level_i),
        .adc_code_o  (adc_code_o),
        .rx_bits_o   (rx_bits)
    );

    prbs_gen i_prbs_gen (
        .clk_adc     (clk_adc),
        .cdr_rstb    (cdr_rstb),
        .gen_cke_i   (gen_cke_i),
        .inj_err_i   (inj_err_i),
        .bist_bits_o (bist_bits)
    );

    prbs_checker i_prbs_checker (
        .clk_adc     (clk_adc),
        .cdr_rstb    (cdr_rstb),
        .chk_cke_i   (chk_cke_i),
        .sel_bist_i  (sel_bist_i),
        .chan_sel_i  (chan_sel_i),
        .rx_bits_i   (rx_bits),
        .bist_bits_i (bist_bits),
        .count_sel_i (count_sel_i),
        .count_o     (count_o)
    );

    cdr_pi_ctl i_cdr_pi_ctl (
        .clk_adc        (clk_adc),
        .cdr_rstb       (cdr_rstb),
        .pi_code_i      (pi_code_i),
        .max_sel_i      (max_sel_i),
        .ext_scale_en_i (ext_scale_en_i),
        .ext_scale_i    (ext_scale_i),
        .pi_offset_i    (pi_offset_i),
        .int_pi_ctl_o   (int_pi_ctl_o),
        .ctl_valid_o    (ctl_valid_o)
    );

endmodule

// ==== design/prbs_checker.sv ====
module prbs_checker (
    input  wire logic                       clk_adc,
    input  wire logic                       cdr_rstb,
    input  wire logic                       chk_cke_i,
    input  wire logic                       sel_bist_i,
    input  wire logic [dcore_pkg::n_ti-1:0] chan_sel_i,
    input  wire logic [dcore_pkg::n_ti-1:0] rx_bits_i,
    input  wire logic [dcore_pkg::n_ti-1:0] bist_bits_i,
    input  wire logic [1:0]                 count_sel_i,
    output logic [dcore_pkg::n_half-1:0]    count_o
);

    logic [dcore_pkg::n_ti-1:0]       sel_bits;
    logic [dcore_pkg::prbs_len-1:0]   hist_q;
    logic [dcore_pkg::prbs_len-1:0]   hist_d;
    logic [dcore_pkg::n_ti-1:0]       err_bits;
    logic [1:0]                       fill_q;
    logic                             cmp_en;
    logic [dcore_pkg::n_lane_cnt-1:0] err_num;
    logic [dcore_pkg::n_lane_cnt-1:0] lane_num;
    dcore_pkg::count_word_u           err_q;
    dcore_pkg::count_word_u           tot_q;
    dcore_pkg::count_word_u           rd_word;

    // adc slicer or bist loopback
    assign sel_bits = sel_bist_i ? bist_bits_i : rx_bits_i;

    // history holds 8 bits after two words
    assign cmp_en = fill_q[1];

    //////////////////////////////////////////////////////////////////////
    // self-synchronizing prediction
    //////////////////////////////////////////////////////////////////////

    // each lane is predicted from the received stream, earlier lanes included
    always_comb begin
        hist_d = hist_q;
        err_bits = '0;
        for (int k = 0; k < dcore_pkg::n_ti; k++) begin
            err_bits[k] = sel_bits[k] ^ hist_d[dcore_pkg::prbs_tap_a-1]
                        ^ hist_d[dcore_pkg::prbs_tap_b-1];
            hist_d = {hist_d[dcore_pkg::prbs_len-2:0], sel_bits[k]};
        end
        err_bits = err_bits & chan_sel_i & {dcore_pkg::n_ti{cmp_en}};
    end

    // per-cycle lane counts
    always_comb begin
        err_num = '0;
        lane_num = '0;
        for (int k = 0; k < dcore_pkg::n_ti; k++) begin
            err_num = err_num + dcore_pkg::n_lane_cnt'(err_bits[k]);
            lane_num = lane_num + dcore_pkg::n_lane_cnt'(chan_sel_i[k]);
        end
    end

    //////////////////////////////////////////////////////////////////////
    // counters
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_adc or negedge cdr_rstb) begin
        if (!cdr_rstb) begin
            hist_q <= '0;
            fill_q <= '0;
            err_q  <= '0;
            tot_q  <= '0;
        end else if (chk_cke_i) begin
            hist_q <= hist_d;
            if (!cmp_en) begin
                fill_q <= fill_q + 2'd1;
            end
            err_q.full <= err_q.full + dcore_pkg::n_count'(err_num);
            tot_q.full <= tot_q.full + dcore_pkg::n_count'(lane_num);
        end
    end

    // readout, bit 1 picks total over errors, bit 0 the upper half
    assign rd_word = count_sel_i[1] ? tot_q : err_q;
    assign count_o = count_sel_i[0] ? rd_word.half.upper : rd_word.half.lower;

endmodule

// ==== design/prbs_gen.sv ====
module prbs_gen (
    input  wire logic                       clk_adc,
    input  wire logic                       cdr_rstb,
    input  wire logic                       gen_cke_i,
    input  wire logic                       inj_err_i,
    output logic [dcore_pkg::n_ti-1:0]      bist_bits_o
);

    logic [dcore_pkg::prbs_len-1:0] state_q;
    logic [dcore_pkg::prbs_len-1:0] state_d;
    logic [dcore_pkg::n_ti-1:0]     word_d;
    logic [dcore_pkg::n_ti-1:0]     flip_d;
    logic                           inj_pend_q;

    //////////////////////////////////////////////////////////////////////
    // four lfsr steps per cycle
    //////////////////////////////////////////////////////////////////////

    // state bit 0 holds the latest bit, lane 0 is the earliest of the word
    always_comb begin
        state_d = state_q;
        for (int k = 0; k < dcore_pkg::n_ti; k++) begin
            word_d[k] = state_d[dcore_pkg::prbs_tap_a-1] ^ state_d[dcore_pkg::prbs_tap_b-1];
            state_d = {state_d[dcore_pkg::prbs_len-2:0], word_d[k]};
        end
    end

    // injected error only touches the output, never the state
    assign flip_d = {{(dcore_pkg::n_ti-1){1'b0}}, inj_err_i | inj_pend_q};

    always_ff @(posedge clk_adc or negedge cdr_rstb) begin
        if (!cdr_rstb) begin
            state_q     <= dcore_pkg::prbs_seed;
            bist_bits_o <= '0;
            inj_pend_q  <= 1'b0;
        end else if (gen_cke_i) begin
            state_q     <= state_d;
            bist_bits_o <= word_d ^ flip_d;
            inj_pend_q  <= 1'b0;
        end else begin
            // hold a pulse that lands while stalled
            inj_pend_q  <= inj_pend_q | inj_err_i;
        end
    end

endmodule

// ==== sim.f ====
design/dcore_pkg.sv
design/adc_unfold.sv
design/prbs_gen.sv
design/prbs_checker.sv
design/cdr_pi_ctl.sv
design/dcore_top.sv
sim/tb_dcore.sv

// ==== sim/dcore_testdata.txt ====
# U mag0 mag1 mag2 mag3 signs(bit k = lane k) code0 code1 code2 code3, all hex
# P ext_en code max_sel ext_scale offset expected, all hex
U 10 20 30 40 f 10 20 30 40
U 10 20 30 40 0 f0 e0 d0 c0
U 00 7f 80 ff 5 00 81 80 01
U 01 02 03 04 a ff 02 fd 04
U 00 00 00 00 0 00 00 00 00
U 55 aa 33 cc 3 55 aa cd 34
U 7f 7f 7f 7f 6 81 7f 7f 81
U 08 10 18 20 9 08 f0 e8 20
P 0 64 0 0 0 a
P 0 64 0 0 5 f
P 0 1ff 1f 0 0 0
P 0 1fe 1f 0 3 1
P 0 12c 7 0 a 38
P 0 25 1 0 0 6
P 0 ff f 0 64 64
P 0 0 3 0 1ff 1ff
P 0 3f 3 0 0 0
P 0 40 3 0 0 1
P 1 64 0 32 0 0
P 1 7b 0 a 7 a
P 1 190 0 1ff c8 58
P 1 4d 3 d 1 d
P 1 1f3 0 1f4 14 7
P 1 5 0 1 0 0
P 1 1ff 0 100 0 ff
P 1 10 1f 11 2 12

// ==== sim/tb_dcore.sv ====
module tb_dcore;

    timeunit 1ns;
    timeprecision 1ps;

    localparam realtime clk_period = 4ns;
    localparam logic [31:0] rand_seed = 32'h533ea561;
    // reset 5, valid wait 40, counter reads 6, data file 34, random 200, slicing 140, bist 136
    localparam int planned_cycles = 561;
    localparam int timeout_limit = 4 * planned_cycles;

    logic        clk_adc;
    logic        cdr_rstb;
    logic [7:0]  adc_mag [4];
    logic [3:0]  adc_sign;
    logic signed [7:0] bit_level;
    logic signed [7:0] adc_code [4];
    logic        gen_cke;
    logic        inj_err;
    logic        chk_cke;
    logic        sel_bist;
    logic [3:0]  chan_sel;
    logic [1:0]  count_sel;
    logic [31:0] count;
    logic [8:0]  pi_code [4];
    logic [4:0]  max_sel [4];
    logic        ext_scale_en;
    logic [8:0]  ext_scale [4];
    logic [8:0]  pi_offset [4];
    logic [8:0]  int_pi_ctl [4];
    logic        ctl_valid;

    int          cycle_cnt;
    logic [31:0] rng_state;
    logic [63:0] exp_total;

    dcore_top i_dcore_top (
        .clk_adc        (clk_adc),
        .cdr_rstb       (cdr_rstb),
        .adc_mag_i      (adc_mag),
        .adc_sign_i     (adc_sign),
        .bit_level_i    (bit_level),
        .adc_code_o     (adc_code),
        .gen_cke_i      (gen_cke),
        .inj_err_i      (inj_err),
        .chk_cke_i      (chk_cke),
        .sel_bist_i     (sel_bist),
        .chan_sel_i     (chan_sel),
        .count_sel_i    (count_sel),
        .count_o        (count),
        .pi_code_i      (pi_code),
        .max_sel_i      (max_sel),
        .ext_scale_en_i (ext_scale_en),
        .ext_scale_i    (ext_scale),
        .pi_offset_i    (pi_offset),
        .int_pi_ctl_o   (int_pi_ctl),
        .ctl_valid_o    (ctl_valid)
    );

    initial begin
        clk_adc = 1'b0;
        forever #(clk_period / 2) clk_adc = ~clk_adc;
    end

    always @(posedge clk_adc) begin
        cycle_cnt++;
        if (cycle_cnt > timeout_limit) begin
            $display("timeout: the run took more than %0d clock cycles", timeout_limit);
            $display("STATUS: FAIL");
            $fatal(1, "simulation stopped on timeout");
        end
    end

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("ERROR time=%0t signal=%s got=0x%0h expected=0x%0h", $time, name, got, exp);
            $display("STATUS: FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    function automatic logic [31:0] xorshift32();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic int lane_count(input logic [3:0] mask);
        int n;
        n = 0;
        for (int k = 0; k < 4; k++) begin
            n += mask[k];
        end
        return n;
    endfunction

    // wrap into the interpolator range, add offset, keep 9 bits
    function automatic logic [8:0] pi_expect(input int code, input int ms, input bit ext,
                                             input int ext_sc, input int off);
        int sc;
        sc = ext ? ext_sc : ((((ms + 1) * 16) - 1) & 511);
        return 9'(((code % sc) + off) & 511);
    endfunction

    // reads both halves over two falling edges and rebuilds the 64-bit count
    task automatic read_count(input logic total, output logic [63:0] value);
        dcore_pkg::count_word_u w;
        @(negedge clk_adc);
        count_sel = {total, 1'b1};
        @(negedge clk_adc);
        w.half.upper = count;
        count_sel = {total, 1'b0};
        @(negedge clk_adc);
        w.half.lower = count;
        value = w.full;
    endtask

    // n cycles with the checker enabled and an injection pulse at cycle inj_at
    task automatic run_enabled(input int n, input bit bist, input int inj_at);
        for (int i = 0; i < n; i++) begin
            @(negedge clk_adc);
            gen_cke = bist;
            chk_cke = 1'b1;
            inj_err = (i == inj_at);
            exp_total += lane_count(chan_sel);
        end
        @(negedge clk_adc);
        gen_cke = 1'b0;
        chk_cke = 1'b0;
        inj_err = 1'b0;
    endtask

    // error count delta over n steady cycles after a warm-up of 3
    task automatic measure(input bit bist, input int n, input int inj_at,
                           input logic [63:0] exp_delta);
        logic [63:0] e0;
        logic [63:0] e1;
        logic [63:0] tot;
        run_enabled(3, bist, -1);
        read_count(1'b0, e0);
        run_enabled(n, bist, inj_at);
        read_count(1'b0, e1);
        read_count(1'b1, tot);
        check_value("count_o errors delta", e1 - e0, exp_delta);
        check_value("count_o total", tot, exp_total);
    endtask

    task automatic slice_case(input logic [3:0] signs, input logic [7:0] mag,
                              input logic signed [7:0] level, input int per_cycle);
        @(negedge clk_adc);
        for (int k = 0; k < 4; k++) begin
            adc_mag[k] = mag;
        end
        adc_sign = signs;
        bit_level = level;
        measure(1'b0, 20, -1, 64'(per_cycle * 20));
    endtask

    task automatic apply_pi(input bit ext, input int code, input int ms, input int sc,
                            input int off, input logic [8:0] exp);
        @(negedge clk_adc);
        ext_scale_en = ext;
        for (int j = 0; j < 4; j++) begin
            pi_code[j] = 9'(code);
            max_sel[j] = 5'(ms);
            ext_scale[j] = 9'(sc);
            pi_offset[j] = 9'(off);
        end
        #1;
        for (int j = 0; j < 4; j++) begin
            check_value($sformatf("int_pi_ctl_o[%0d]", j), 64'(int_pi_ctl[j]), 64'(exp));
        end
    endtask

    task automatic run_data_file();
        int fd;
        int n;
        string line;
        string tag;
        logic [31:0] v [9];
        logic [7:0] code_u;
        fd = $fopen("sim/dcore_testdata.txt", "r");
        if (fd == 0) begin
            $display("the data file sim/dcore_testdata.txt could not be opened");
            $display("STATUS: FAIL");
            $fatal(1, "missing data file");
        end
        while (!$feof(fd)) begin
            n = $fgets(line, fd);
            if (n > 1 && line[0] != "#") begin
                n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h", tag,
                            v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8]);
                if (tag == "U") begin
                    @(negedge clk_adc);
                    for (int k = 0; k < 4; k++) begin
                        adc_mag[k] = v[k][7:0];
                        adc_sign[k] = v[4][k];
                    end
                    @(negedge clk_adc);
                    for (int k = 0; k < 4; k++) begin
                        code_u = adc_code[k];
                        check_value($sformatf("adc_code_o[%0d]", k), 64'(code_u),
                                    64'(v[5 + k][7:0]));
                    end
                end else if (tag == "P") begin
                    apply_pi(v[0][0], v[1], v[2], v[3], v[4], v[5][8:0]);
                end
            end
        end
        $fclose(fd);
    endtask

    initial begin
        logic [63:0] val;
        int code;
        int ms;
        int sc;
        int off;
        bit ext;
        cycle_cnt = 0;
        rng_state = rand_seed;
        exp_total = '0;
        cdr_rstb = 1'b0;
        adc_sign = '0;
        bit_level = '0;
        gen_cke = 1'b0;
        inj_err = 1'b0;
        chk_cke = 1'b0;
        sel_bist = 1'b0;
        chan_sel = 4'hf;
        count_sel = 2'b00;
        ext_scale_en = 1'b0;
        for (int k = 0; k < 4; k++) begin
            adc_mag[k] = '0;
            pi_code[k] = '0;
            max_sel[k] = '0;
            ext_scale[k] = 9'd1;
            pi_offset[k] = '0;
        end
        repeat (5) @(negedge clk_adc);
        cdr_rstb = 1'b1;

        // post-reset valid wait and the idle counter values
        for (int k = 1; k <= 40; k++) begin
            @(negedge clk_adc);
            check_value("ctl_valid_o", 64'(ctl_valid), 64'(k >= 32));
        end
        read_count(1'b0, val);
        check_value("count_o errors", val, 64'd0);
        read_count(1'b1, val);
        check_value("count_o total", val, 64'd0);

        run_data_file();

        // random pi codes in both scale modes
        for (int i = 0; i < 200; i++) begin
            code = xorshift32() & 511;
            ms = xorshift32() & 31;
            sc = (xorshift32() % 511) + 1;
            off = xorshift32() & 511;
            ext = xorshift32() & 1;
            apply_pi(ext, code, ms, sc, off, pi_expect(code, ms, ext, sc, off));
        end

        ///////////////////////////////////////////////////////////////////
        // slicing seen through the checker
        ///////////////////////////////////////////////////////////////////

        // alternating lanes predict a one every bit so the zeros mismatch
        slice_case(4'b0101, 8'd9, 8'sd0, 2);
        // all ones predict zero and every lane mismatches
        slice_case(4'b1111, 8'd21, 8'sd20, 4);
        // equal to the level slices as zero
        slice_case(4'b1111, 8'd20, 8'sd20, 0);
        slice_case(4'b0000, 8'd5, -8'sd6, 4);

        ///////////////////////////////////////////////////////////////////
        // bist loopback, injection and lane mask
        ///////////////////////////////////////////////////////////////////

        @(negedge clk_adc);
        sel_bist = 1'b1;
        measure(1'b1, 50, -1, 64'd0);
        measure(1'b1, 12, 4, 64'd3);
        @(negedge clk_adc);
        chan_sel = 4'b0101;
        measure(1'b1, 30, -1, 64'd0);

        $display("STATUS: PASS");
        $finish;
    end

endmodule
